// ==== rtl/div_settings.svh ====
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// APB address width in bits
`define DIV_APB_AW 5

// Register byte offsets
`define DIV_REG_OPA    5'h00
`define DIV_REG_OPB    5'h04
`define DIV_REG_CTRL   5'h08
`define DIV_REG_STATUS 5'h0C
`define DIV_REG_RESULT 5'h10

// Command word fields, opcode takes two bits from the LSB
`define DIV_CTRL_OP_LSB    0
`define DIV_CTRL_DIT_BIT   2
`define DIV_CTRL_ABORT_BIT 3

// Status word fields
`define DIV_STAT_BUSY_BIT 0
`define DIV_STAT_DONE_BIT 1

`endif

// ==== rtl/div_pkg.sv ====
`default_nettype none

package div_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Divide opcodes
  ////////////////////////////////////////////////////////////////////////////

  // Encoding matches the two opcode bits of the command word
  typedef enum logic [1:0] {
    DIV_DIV  = 2'd0,
    DIV_DIVU = 2'd1,
    DIV_REM  = 2'd2,
    DIV_REMU = 2'd3
  } div_opcode_e;

  ////////////////////////////////////////////////////////////////////////////
  // Serial divider FSM states
  ////////////////////////////////////////////////////////////////////////////

  // IDLE doubles as the init cycle when a request is present
  typedef enum logic [1:0] {
    DIV_IDLE   = 2'd0,
    DIV_DIVIDE = 2'd1,
    DIV_DUMMY  = 2'd2,
    DIV_FINISH = 2'd3
  } div_state_e;

endpackage

`default_nettype wire

// ==== rtl/div_clz_shift.sv ====
`timescale 1ns/100ps
`default_nettype none

module div_clz_shift (
  // Normalisation word, bit reversed
  input  logic [31:0] clz_data_rev_i,
  // Raw divisor
  input  logic [31:0] op_b_i,
  // High only in the divider init cycle
  input  logic        en_i,
  output logic [5:0]  clz_result_o,
  output logic [31:0] op_b_shifted_o
);

  logic [31:0] data_gated;
  logic [31:0] op_b_gated;
  logic [5:0]  zero_cnt;

  // Hold inputs at zero outside init so the logic stays quiet
  assign data_gated = en_i ? clz_data_rev_i : '0;
  assign op_b_gated = en_i ? op_b_i : '0;

  // Trailing zeros of the reversed word are the leading zeros of the original
  // Scan from the top so the lowest set bit wins, all zero gives 32
  always_comb begin
    zero_cnt = 6'd32;
    for (int i = 31; i >= 0; i--) begin
      if (data_gated[i]) begin
        zero_cnt = 6'(i);
      end
    end
  end

  assign clz_result_o = en_i ? zero_cnt : 6'd0;

  // Count of 32 pushes everything out
  assign op_b_shifted_o = zero_cnt[5] ? 32'd0 : (op_b_gated << zero_cnt[4:0]);

endmodule

`default_nettype wire

// ==== rtl/div_serial.sv ====
`timescale 1ns/100ps
`default_nettype none

module div_serial import div_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // Operation
  input  div_opcode_e operator_i,
  input  logic        data_ind_timing_i,
  input  logic [31:0] op_a_i,
  input  logic [31:0] op_b_i,
  // Handshake, valid_i low kills the divide
  input  logic        valid_i,
  input  logic        ready_i,
  output logic        valid_o,
  output logic        ready_o,
  output logic [31:0] result_o,
  // Normalisation helper
  output logic [31:0] clz_data_rev_o,
  input  logic [5:0]  clz_result_i,
  output logic [31:0] op_b_raw_o,
  input  logic [31:0] op_b_shifted_i
);

  div_state_e  state_q;
  div_state_e  state_d;
  logic [31:0] quotient_q;
  logic [31:0] remainder_q;
  logic [31:0] divisor_q;
  logic [31:0] norm_word;
  logic [31:0] add_out;
  logic [31:0] res_mux;
  logic [5:0]  cnt_q;
  logic [5:0]  cnt_d;
  logic [5:0]  shift_q;
  logic [5:0]  dummy_cnt;
  logic        div_signed;
  logic        div_rem;
  logic        op_b_is_neg;
  logic        op_b_is_zero;
  logic        init_rem_pos;
  logic        rem_sel_q;
  logic        comp_inv_q;
  logic        res_inv_q;
  logic        b_zero_q;
  logic        init_en;
  logic        dummy_en;
  logic        remainder_en;
  logic        quotient_en;
  logic        comp_out;
  logic        cnt_is_zero;

  ////////////////////////////////////////////////////////////////////////////
  // Operator decode and normalisation
  ////////////////////////////////////////////////////////////////////////////

  assign div_signed   = (operator_i == DIV_DIV) || (operator_i == DIV_REM);
  assign div_rem      = (operator_i == DIV_REM) || (operator_i == DIV_REMU);
  assign op_b_is_neg  = op_b_i[31] & div_signed;
  assign op_b_is_zero = ~|op_b_i;

  // Negative divisor counts leading ones and keeps one bit for the sign
  assign norm_word      = op_b_is_neg ? {~op_b_i[30:0], 1'b1} : op_b_i;
  assign clz_data_rev_o = {<<{norm_word}};
  assign op_b_raw_o     = op_b_i;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  // Dividend is negated when operand signs differ
  assign init_rem_pos = !(div_signed && (op_a_i[31] ^ op_b_is_neg));

  always_comb begin
    if (init_en) begin
      add_out = init_rem_pos ? op_a_i : -op_a_i;
    end else begin
      add_out = remainder_q - divisor_q;
    end
  end

  // Compare flips for a negative divisor, zero divisor always fits
  assign comp_out = ((remainder_q == divisor_q) || ((remainder_q > divisor_q) ^ comp_inv_q)) &&
                    ((|remainder_q) || b_zero_q);

  // Final selection and single negation
  assign res_mux  = rem_sel_q ? remainder_q : quotient_q;
  assign result_o = res_inv_q ? -res_mux : res_mux;

  ////////////////////////////////////////////////////////////////////////////
  // Bit counter
  ////////////////////////////////////////////////////////////////////////////

  assign cnt_is_zero = (cnt_q == 6'd0);
  // Padding that brings every divide to 33 cycles
  assign dummy_cnt   = 6'd32 - shift_q;

  always_comb begin
    cnt_d = cnt_q;
    if (init_en) begin
      cnt_d = clz_result_i;
    end else if (dummy_en) begin
      // One cycle goes to the reload itself
      cnt_d = dummy_cnt - 6'd1;
    end else if (!cnt_is_zero) begin
      cnt_d = cnt_q - 6'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    valid_o      = 1'b0;
    init_en      = 1'b0;
    dummy_en     = 1'b0;
    remainder_en = 1'b0;
    quotient_en  = 1'b0;
    case (state_q)
      DIV_IDLE: begin
        if (valid_i) begin
          init_en = 1'b1;
          state_d = DIV_DIVIDE;
        end
      end
      DIV_DIVIDE: begin
        remainder_en = comp_out;
        quotient_en  = 1'b1;
        // Last quotient bit this cycle
        if (cnt_is_zero) begin
          if (data_ind_timing_i && (dummy_cnt != 6'd0)) begin
            dummy_en = 1'b1;
            state_d  = DIV_DUMMY;
          end else begin
            state_d = DIV_FINISH;
          end
        end
      end
      DIV_DUMMY: begin
        if (cnt_is_zero) begin
          state_d = DIV_FINISH;
        end
      end
      DIV_FINISH: begin
        valid_o = 1'b1;
        if (ready_i) begin
          state_d = DIV_IDLE;
        end
      end
      default: state_d = DIV_IDLE;
    endcase
    // Kill from any state
    if (!valid_i) begin
      state_d = DIV_IDLE;
      valid_o = 1'b0;
    end
  end

  // Operands are taken in the init cycle
  assign ready_o = init_en;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= DIV_IDLE;
      cnt_q      <= '0;
      shift_q    <= '0;
      rem_sel_q  <= 1'b0;
      comp_inv_q <= 1'b0;
      res_inv_q  <= 1'b0;
      b_zero_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (init_en) begin
        shift_q    <= clz_result_i;
        rem_sel_q  <= div_rem;
        comp_inv_q <= op_b_is_neg;
        b_zero_q   <= op_b_is_zero;
        // Divide by zero keeps the all-ones quotient as it is
        res_inv_q  <= (!op_b_is_zero || div_rem) && div_signed &&
                      (op_a_i[31] ^ op_b_is_neg);
      end
    end
  end

  // Working registers
  always_ff @(posedge clk) begin
    if (init_en || remainder_en) begin
      remainder_q <= add_out;
    end
    if (init_en) begin
      divisor_q <= op_b_shifted_i;
    end else if (state_q == DIV_DIVIDE) begin
      // Sign fill for a negative divisor
      divisor_q <= {comp_inv_q, divisor_q[31:1]};
    end
    if (init_en) begin
      quotient_q <= '0;
    end else if (quotient_en) begin
      quotient_q <= {quotient_q[30:0], comp_out};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/div_apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "div_settings.svh"

module div_apb_regs import div_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  // APB slave
  input  logic [`DIV_APB_AW-1:0] paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  // Request towards the divider
  output logic                   div_valid_o,
  output div_opcode_e            div_op_o,
  output logic                   div_dit_o,
  output logic [31:0]            op_a_o,
  output logic [31:0]            op_b_o,
  // Result from the divider
  input  logic                   div_valid_i,
  input  logic [31:0]            div_result_i,
  output logic                   div_ready_o
);

  logic        apb_access;
  logic        apb_write;
  logic        apb_read;
  logic        sel_opa;
  logic        sel_opb;
  logic        sel_ctrl;
  logic        sel_status;
  logic        sel_result;
  logic        addr_hit;
  logic        start_req;
  logic        abort_req;
  logic        start_err;
  logic        ro_write;
  logic        result_take;
  logic        busy_q;
  logic        done_q;
  logic        dit_q;
  div_opcode_e op_q;
  logic [31:0] op_a_q;
  logic [31:0] op_b_q;
  logic [31:0] result_q;
  logic [31:0] ctrl_word;
  logic [31:0] status_word;

  ////////////////////////////////////////////////////////////////////////////
  // Address and command decode
  ////////////////////////////////////////////////////////////////////////////

  // Everything acts in the access phase, no wait states
  assign apb_access = psel_i & penable_i;
  assign apb_write  = apb_access & pwrite_i;
  assign apb_read   = apb_access & ~pwrite_i;

  assign sel_opa    = (paddr_i == `DIV_REG_OPA);
  assign sel_opb    = (paddr_i == `DIV_REG_OPB);
  assign sel_ctrl   = (paddr_i == `DIV_REG_CTRL);
  assign sel_status = (paddr_i == `DIV_REG_STATUS);
  assign sel_result = (paddr_i == `DIV_REG_RESULT);
  assign addr_hit   = sel_opa | sel_opb | sel_ctrl | sel_status | sel_result;

  // A CTRL write is either an abort or a start
  assign abort_req = apb_write & sel_ctrl & pwdata_i[`DIV_CTRL_ABORT_BIT];
  assign start_req = apb_write & sel_ctrl & ~pwdata_i[`DIV_CTRL_ABORT_BIT];
  // Start while busy is refused and changes nothing
  assign start_err = start_req & busy_q;
  // STATUS and RESULT are read only
  assign ro_write  = apb_write & (sel_status | sel_result);

  assign pslverr_o = (apb_access & ~addr_hit) | ro_write | start_err;
  assign pready_o  = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Divider handshake
  ////////////////////////////////////////////////////////////////////////////

  // Results are never refused
  assign div_ready_o = 1'b1;
  assign result_take = div_valid_i & div_ready_o;

  // Request line is high exactly while busy
  assign div_valid_o = busy_q;
  assign div_op_o    = op_q;
  assign div_dit_o   = dit_q;
  assign op_a_o      = op_a_q;
  assign op_b_o      = op_b_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      dit_q    <= 1'b0;
      op_q     <= DIV_DIV;
      op_a_q   <= '0;
      op_b_q   <= '0;
      result_q <= '0;
    end else begin
      if (apb_write && sel_opa) begin
        op_a_q <= pwdata_i;
      end
      if (apb_write && sel_opb) begin
        op_b_q <= pwdata_i;
      end
      // Capture drops the request in the same edge
      if (result_take) begin
        result_q <= div_result_i;
        busy_q   <= 1'b0;
        done_q   <= 1'b1;
      end
      if (start_req && !busy_q) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
        op_q   <= div_opcode_e'(pwdata_i[`DIV_CTRL_OP_LSB +: 2]);
        dit_q  <= pwdata_i[`DIV_CTRL_DIT_BIT];
      end
      // Abort wins over a result arriving in the same cycle
      if (abort_req) begin
        busy_q <= 1'b0;
        done_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read-back mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_word   = '0;
    status_word = '0;
    ctrl_word[`DIV_CTRL_OP_LSB +: 2]     = op_q;
    ctrl_word[`DIV_CTRL_DIT_BIT]         = dit_q;
    status_word[`DIV_STAT_BUSY_BIT]      = busy_q;
    status_word[`DIV_STAT_DONE_BIT]      = done_q;
  end

  // Zero outside a read access
  always_comb begin
    prdata_o = '0;
    if (apb_read) begin
      case (paddr_i)
        `DIV_REG_OPA:    prdata_o = op_a_q;
        `DIV_REG_OPB:    prdata_o = op_b_q;
        `DIV_REG_CTRL:   prdata_o = ctrl_word;
        `DIV_REG_STATUS: prdata_o = status_word;
        `DIV_REG_RESULT: prdata_o = result_q;
        default:         prdata_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/div_apb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "div_settings.svh"

module div_apb_top import div_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`DIV_APB_AW-1:0] paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  // Register block to divider
  logic        div_valid;
  div_opcode_e div_op;
  logic        div_dit;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic        div_ready_out;
  // Divider back to register block
  logic        div_valid_out;
  logic [31:0] div_result;
  // Divider init flag, enables the helper
  logic        div_accept;
  // Normalisation helper
  logic [31:0] clz_data_rev;
  logic [5:0]  clz_result;
  logic [31:0] op_b_raw;
  logic [31:0] op_b_shifted;

  div_apb_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .div_valid_o (div_valid),
    .div_op_o    (div_op),
    .div_dit_o   (div_dit),
    .op_a_o      (op_a),
    .op_b_o      (op_b),
    .div_valid_i (div_valid_out),
    .div_result_i(div_result),
    .div_ready_o (div_ready_out)
  );

  div_serial u_div (
    .clk              (clk),
    .rst_n            (rst_n),
    .operator_i       (div_op),
    .data_ind_timing_i(div_dit),
    .op_a_i           (op_a),
    .op_b_i           (op_b),
    .valid_i          (div_valid),
    .ready_i          (div_ready_out),
    .valid_o          (div_valid_out),
    .ready_o          (div_accept),
    .result_o         (div_result),
    .clz_data_rev_o   (clz_data_rev),
    .clz_result_i     (clz_result),
    .op_b_raw_o       (op_b_raw),
    .op_b_shifted_i   (op_b_shifted)
  );

  div_clz_shift u_clz (
    .clz_data_rev_i(clz_data_rev),
    .op_b_i        (op_b_raw),
    .en_i          (div_accept),
    .clz_result_o  (clz_result),
    .op_b_shifted_o(op_b_shifted)
  );

endmodule

`default_nettype wire

// ==== test/div_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module div_properties import div_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       valid_i,
  input  logic       valid_o,
  input  div_state_e state_i,
  input  logic       pready_i
);

  // Failed assertions so far, summed into the final verdict
  int fail_cnt = 0;

  // Results are always taken, so the request drops right after valid_o
  a_req_drops_after_result: assert property (
    @(posedge clk) disable iff (!rst_n) valid_o |=> !valid_i)
    else begin
      $error("divider request still high after its result was taken");
      fail_cnt++;
    end

  // Dropped request kills the divide within one cycle
  a_idle_after_kill: assert property (
    @(posedge clk) disable iff (!rst_n) $fell(valid_i) |=> (state_i == DIV_IDLE))
    else begin
      $error("divider not idle one cycle after valid_i fell");
      fail_cnt++;
    end

  // No wait states on the bus
  a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready_i)
    else begin
      $error("pready dropped low");
      fail_cnt++;
    end

endmodule

// Attached at the top so the bus ready sits next to the divider handshake
bind div_apb_top div_properties u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .valid_i (div_valid),
  .valid_o (div_valid_out),
  .state_i (u_div.state_q),
  .pready_i(pready_o)
);

`default_nettype wire

// ==== test/div_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "div_settings.svh"

module div_checker import div_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`DIV_APB_AW-1:0] paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [31:0]            pwdata_i,
  input  logic [31:0]            prdata_i,
  input  logic                   pslverr_i,
  output int                     err_cnt_o,
  output int                     chk_cnt_o
);

  // Host-visible life of one divide
  typedef enum {ST_NONE, ST_RUNNING, ST_DONE, ST_ABORTED} run_state_t;

  run_state_t  run_state;
  div_opcode_e run_op;
  logic        run_dit;
  logic [31:0] model_a;
  logic [31:0] model_b;
  logic [31:0] pending;
  logic [31:0] expect_res;
  int          poll_cnt;
  int          dit_polls;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model, RISC-V M extension rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] expected_result(input div_opcode_e op,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [31:0]        res;
    logic               signed_op;
    sa = a;
    sb = b;
    signed_op = (op == DIV_DIV) || (op == DIV_REM);
    if (b == 32'd0) begin
      // Quotient all ones, remainder is the dividend
      res = ((op == DIV_DIV) || (op == DIV_DIVU)) ? 32'hFFFF_FFFF : a;
    end else if (signed_op && (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF)) begin
      // Signed overflow
      res = (op == DIV_DIV) ? a : 32'd0;
    end else begin
      case (op)
        DIV_DIV:  res = sa / sb;
        DIV_REM:  res = sa % sb;
        DIV_DIVU: res = a / b;
        default:  res = a % b;
      endcase
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    chk_cnt_o++;
    if (act !== exp) begin
      err_cnt_o++;
      $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    chk_cnt_o++;
    if (act != exp) begin
      err_cnt_o++;
      $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus snooping
  ////////////////////////////////////////////////////////////////////////////

  task automatic observe_status();
    logic [31:0] busy_word;
    logic [31:0] done_word;
    busy_word = 32'd1 << `DIV_STAT_BUSY_BIT;
    done_word = 32'd1 << `DIV_STAT_DONE_BIT;
    if (run_state == ST_RUNNING) begin
      poll_cnt++;
      if (prdata_i === done_word) begin
        chk_cnt_o++;
        run_state  = ST_DONE;
        expect_res = pending;
        // First padded divide sets the reference poll count
        if (run_dit && (dit_polls < 0)) begin
          dit_polls = poll_cnt;
        end else if (run_dit) begin
          check_count("status polls with data-independent timing", dit_polls, poll_cnt);
        end
      end else begin
        check_value("STATUS", busy_word, prdata_i);
      end
    end else begin
      check_value("STATUS", (run_state == ST_DONE) ? done_word : 32'd0, prdata_i);
    end
  endtask

  task automatic observe_access();
    logic mapped;
    logic start;
    logic exp_err;
    mapped = (paddr_i == `DIV_REG_OPA) || (paddr_i == `DIV_REG_OPB) ||
             (paddr_i == `DIV_REG_CTRL) || (paddr_i == `DIV_REG_STATUS) ||
             (paddr_i == `DIV_REG_RESULT);
    start = pwrite_i && (paddr_i == `DIV_REG_CTRL) && !pwdata_i[`DIV_CTRL_ABORT_BIT];
    exp_err = !mapped || (start && (run_state == ST_RUNNING)) ||
              (pwrite_i && ((paddr_i == `DIV_REG_STATUS) || (paddr_i == `DIV_REG_RESULT)));
    check_value("pslverr", 32'(exp_err), 32'(pslverr_i));
    if (pwrite_i && !exp_err) begin
      case (paddr_i)
        `DIV_REG_OPA: model_a = pwdata_i;
        `DIV_REG_OPB: model_b = pwdata_i;
        `DIV_REG_CTRL: begin
          if (pwdata_i[`DIV_CTRL_ABORT_BIT]) begin
            run_state = ST_ABORTED;
          end else begin
            run_op    = div_opcode_e'(pwdata_i[`DIV_CTRL_OP_LSB +: 2]);
            run_dit   = pwdata_i[`DIV_CTRL_DIT_BIT];
            pending   = expected_result(run_op, model_a, model_b);
            run_state = ST_RUNNING;
            poll_cnt  = 0;
          end
        end
        default: begin
        end
      endcase
    end else if (!pwrite_i && (paddr_i == `DIV_REG_STATUS)) begin
      observe_status();
    end else if (!pwrite_i && (paddr_i == `DIV_REG_RESULT)) begin
      // Result holds the last completed divide
      check_value("RESULT", expect_res, prdata_i);
    end
  endtask

  // Access phase sampled mid-cycle, away from both drive and capture edges
  always @(negedge clk) begin
    if (!rst_n) begin
      run_state  = ST_NONE;
      run_op     = DIV_DIV;
      run_dit    = 1'b0;
      model_a    = '0;
      model_b    = '0;
      pending    = '0;
      expect_res = '0;
      poll_cnt   = 0;
      dit_polls  = -1;
      err_cnt_o  = 0;
      chk_cnt_o  = 0;
    end else if (psel_i && penable_i) begin
      observe_access();
    end
  end

endmodule

`default_nettype wire

// ==== test/div_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "div_settings.svh"

module div_tb import div_pkg::*; ();

  localparam int CLK_PERIOD    = 4;
  localparam int N_RANDOM      = 40;
  localparam int N_DIT         = 8;
  // Reset check, random, corner, status, padded timing, abort
  localparam int N_OPS         = 1 + N_RANDOM + 8 + 1 + N_DIT + 2;
  localparam int CYCLES_PER_OP = 200;
  localparam int MAX_POLLS     = 40;

  logic                   clk;
  logic                   rst_n;
  logic [`DIV_APB_AW-1:0] paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  int                     chk_errors;
  int                     chk_checks;
  int                     tb_errors;
  int                     tests_run;
  int                     tests_failed;
  int                     test_mark;
  int                     total;
  string                  test_name;
  logic [31:0]            rd_data;

  always #(CLK_PERIOD / 2) clk = ~clk;

  div_apb_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .paddr_i  (paddr),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .pwdata_i (pwdata),
    .prdata_o (prdata),
    .pready_o (pready),
    .pslverr_o(pslverr)
  );

  div_checker u_check (
    .clk      (clk),
    .rst_n    (rst_n),
    .paddr_i  (paddr),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .pwdata_i (pwdata),
    .prdata_i (prdata),
    .pslverr_i(pslverr),
    .err_cnt_o(chk_errors),
    .chk_cnt_o(chk_checks)
  );

  ////////////////////////////////////////////////////////////////////////////
  // APB master
  ////////////////////////////////////////////////////////////////////////////

  // Setup, access, then one idle cycle; inputs move 1 ns after the edge
  task automatic apb_access(input logic [`DIV_APB_AW-1:0] addr, input logic write,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk);
    #1;
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [`DIV_APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(addr, 1'b1, data, unused);
  endtask

  task automatic reg_read(input logic [`DIV_APB_AW-1:0] addr, output logic [31:0] data);
    apb_access(addr, 1'b0, 32'd0, data);
  endtask

  function automatic logic [31:0] make_ctrl(input div_opcode_e op, input logic dit,
                                            input logic abort);
    logic [31:0] word;
    word = '0;
    word[`DIV_CTRL_OP_LSB +: 2]  = op;
    word[`DIV_CTRL_DIT_BIT]      = dit;
    word[`DIV_CTRL_ABORT_BIT]    = abort;
    return word;
  endfunction

  // Mostly random, one in five a corner value
  function automatic logic [31:0] rand_operand();
    logic [31:0] val;
    val = $urandom;
    if ($urandom_range(4, 0) == 0) begin
      case ($urandom_range(3, 0))
        0:       val = 32'd0;
        1:       val = 32'hFFFF_FFFF;
        2:       val = 32'h8000_0000;
        default: val = $urandom_range(7, 1);
      endcase
    end
    return val;
  endfunction

  function automatic div_opcode_e rand_op();
    return div_opcode_e'(2'($urandom_range(3, 0)));
  endfunction

  task automatic wait_done();
    logic [31:0] status;
    int          polls;
    status = '0;
    polls  = 0;
    while (!status[`DIV_STAT_DONE_BIT] && (polls < MAX_POLLS)) begin
      reg_read(`DIV_REG_STATUS, status);
      polls++;
    end
    if (!status[`DIV_STAT_DONE_BIT]) begin
      tb_errors++;
      $display("Divider never reported done within %0d status polls, time %0t",
               MAX_POLLS, $time);
    end
  endtask

  task automatic run_divide(input div_opcode_e op, input logic dit,
                            input logic [31:0] a, input logic [31:0] b);
    logic [31:0] data;
    reg_write(`DIV_REG_OPA, a);
    reg_write(`DIV_REG_OPB, b);
    reg_write(`DIV_REG_CTRL, make_ctrl(op, dit, 1'b0));
    wait_done();
    reg_read(`DIV_REG_RESULT, data);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  function automatic int errors_so_far();
    return chk_errors + tb_errors + UUT.u_props.fail_cnt;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_mark = errors_so_far();
  endtask

  task automatic end_test();
    tests_run++;
    if (errors_so_far() > test_mark) begin
      tests_failed++;
      $display("Test %0d %s: failed", tests_run, test_name);
    end else begin
      $display("Test %0d %s: passed", tests_run, test_name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h48e0));
    clk          = 1'b0;
    rst_n        = 1'b0;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    tb_errors    = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("reset values");
    reg_read(`DIV_REG_STATUS, rd_data);
    reg_read(`DIV_REG_RESULT, rd_data);
    end_test();

    start_test("random operands, all opcodes");
    for (int i = 0; i < N_RANDOM; i++) begin
      run_divide(rand_op(), 1'b0, rand_operand(), rand_operand());
    end
    end_test();

    start_test("divide by zero and signed overflow");
    for (int k = 0; k < 4; k++) begin
      run_divide(div_opcode_e'(2'(k)), 1'b0, rand_operand(), 32'd0);
      run_divide(div_opcode_e'(2'(k)), 1'b0, 32'h8000_0000, 32'hFFFF_FFFF);
    end
    end_test();

    // Divisor 1 keeps the divider busy for the full quotient length
    start_test("status and bus errors");
    reg_write(`DIV_REG_OPA, rand_operand());
    reg_write(`DIV_REG_OPB, 32'd1);
    reg_write(`DIV_REG_CTRL, make_ctrl(DIV_DIVU, 1'b0, 1'b0));
    reg_read(`DIV_REG_STATUS, rd_data);
    reg_write(`DIV_REG_CTRL, make_ctrl(DIV_REM, 1'b0, 1'b0));
    reg_read(5'h14, rd_data);
    reg_write(`DIV_REG_STATUS, 32'hFFFF_FFFF);
    reg_write(`DIV_REG_RESULT, 32'h1234_5678);
    wait_done();
    reg_read(`DIV_REG_RESULT, rd_data);
    end_test();

    start_test("data-independent timing");
    for (int i = 0; i < N_DIT; i++) begin
      run_divide(rand_op(), 1'b1, rand_operand(), rand_operand());
    end
    end_test();

    start_test("abort and restart");
    reg_write(`DIV_REG_OPA, rand_operand());
    reg_write(`DIV_REG_OPB, 32'd1);
    reg_write(`DIV_REG_CTRL, make_ctrl(DIV_DIVU, 1'b0, 1'b0));
    reg_write(`DIV_REG_CTRL, make_ctrl(DIV_DIV, 1'b0, 1'b1));
    reg_read(`DIV_REG_STATUS, rd_data);
    reg_read(`DIV_REG_RESULT, rd_data);
    run_divide(rand_op(), 1'b0, rand_operand(), rand_operand());
    end_test();

    total = errors_so_far();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, chk_checks, total);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog, generous budget per divide
  initial begin
    #(N_OPS * CYCLES_PER_OP * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles",
             N_OPS * CYCLES_PER_OP);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/div_pkg.sv
rtl/div_clz_shift.sv
rtl/div_serial.sv
rtl/div_apb_regs.sv
rtl/div_apb_top.sv
test/div_properties.sv
test/div_checker.sv
test/div_tb.sv
